// ==== hw/tcb_lite_params.svh ====
/*
 * Build-time settings of the TCB-Lite subsystem.
 * Bus widths, subordinate count, memory depth, response delay and
 * the decoder address map. Include it wherever a width or the map is needed.
 */

`ifndef TCB_LITE_PARAMS_SVH
`define TCB_LITE_PARAMS_SVH

// bus widths
`define TCB_ADR 32
`define TCB_DAT 32

// interconnect
`define TCB_IFN 2
`define TCB_DLY 1

// words per memory subordinate
`define TCB_MEM_SIZ 256

// address map, x bits are wildcards for ==?
// ram claims 0x0000_0000 .. 0x0000_03ff
`define TCB_MAP_RAM 32'b0000_0000_0000_0000_0000_00xx_xxxx_xxxx
// rom catches everything else (entry 0 wins)
`define TCB_MAP_ROM 32'bxxxx_xxxx_xxxx_xxxx_xxxx_xxxx_xxxx_xxxx

`endif

// ==== hw/tcb_lite_pkg.sv ====
/*
 * TCB-Lite bus protocol types.
 * Opcode enum plus the request and response payload structs that
 * travel inside tcb_lite_if. Import wherever the payload fields are used.
 */

`default_nettype none

`include "tcb_lite_params.svh"

package tcb_lite_pkg;

    //////////////////////////////////////////////////
    // opcode
    //////////////////////////////////////////////////

    typedef enum logic {
        TCB_RD = 1'b0,  // read
        TCB_WR = 1'b1   // write
    } tcb_op_t;

    //////////////////////////////////////////////////
    // payloads
    //////////////////////////////////////////////////

    // request, 1 + adr + dat bits
    typedef struct packed {
        tcb_op_t             op;
        logic [`TCB_ADR-1:0] adr;
        logic [`TCB_DAT-1:0] wdt;
    } tcb_req_t;

    // response, read data and error flag
    typedef struct packed {
        logic [`TCB_DAT-1:0] rdt;
        logic                err;
    } tcb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/tcb_lite_sys_pkg.sv ====
/*
 * Subsystem-level types.
 * Subordinate select index shared by decoder and demultiplexer,
 * and the state encoding of the memory subordinate.
 */

`default_nettype none

`include "tcb_lite_params.svh"

package tcb_lite_sys_pkg;

    // index of one subordinate
    typedef logic [$clog2(`TCB_IFN)-1:0] tcb_sel_t;

    // memory write-commit FSM
    typedef enum logic {
        MEM_IDLE   = 1'b0,  // ready for any request
        MEM_COMMIT = 1'b1   // one stall cycle after a write
    } mem_state_t;

endpackage

`default_nettype wire

// ==== hw/tcb_lite_if.sv ====
/*
 * TCB-Lite point-to-point interface.
 * Request valid/ready handshake, response valid pulse a fixed delay
 * after each transfer with no back-pressure.
 * Managers connect through the man modport, subordinates through sub.
 */

`default_nettype none

interface tcb_lite_if;

    import tcb_lite_pkg::*;

    //////////////////////////////////////////////////
    // signals
    //////////////////////////////////////////////////

    // request, manager to subordinate
    logic     vld;
    tcb_req_t req;
    // request accept, subordinate to manager
    logic     rdy;
    // response, subordinate to manager
    logic     rsp_vld;
    tcb_rsp_t rsp;

    //////////////////////////////////////////////////
    // modports
    //////////////////////////////////////////////////

    // manager drives the request side
    modport man (
        output vld, req,
        input  rdy, rsp_vld, rsp
    );

    // subordinate answers
    modport sub (
        input  vld, req,
        output rdy, rsp_vld, rsp
    );

endinterface

`default_nettype wire

// ==== hw/tcb_lite_lib_decoder.sv ====
/*
 * TCB-Lite address decoder.
 * Matches the request address against an address/mask table with
 * wildcard equality and returns the index of the lowest matching entry.
 * Purely combinational, it only observes the bus.
 */

`default_nettype none

`include "tcb_lite_params.svh"

module tcb_lite_lib_decoder #(
    // address patterns, x bits are don't care
    parameter logic [`TCB_ADR-1:0] DAM [`TCB_IFN-1:0] = '{default: `TCB_MAP_ROM}
)(
    tcb_lite_if.sub                tcb,  // observed, nothing driven
    output tcb_lite_sys_pkg::tcb_sel_t sel
);

    import tcb_lite_sys_pkg::*;

    //////////////////////////////////////////////////
    // match
    //////////////////////////////////////////////////

    // one bit per table entry
    logic [`TCB_IFN-1:0] mch;

    for (genvar i = 0; i < `TCB_IFN; i++) begin : gen_mch
        assign mch[i] = (tcb.req.adr ==? DAM[i]);
    end

    //////////////////////////////////////////////////
    // priority encode
    //////////////////////////////////////////////////

    // lowest set bit wins, walk down so it is written last
    function automatic tcb_sel_t encode(input logic [`TCB_IFN-1:0] val);
        tcb_sel_t idx;
        idx = '0;
        for (int i = `TCB_IFN-1; i >= 0; i--) begin
            if (val[i]) begin
                idx = tcb_sel_t'(i);
            end
        end
        return idx;
    endfunction

    // catch-all last entry keeps this defined
    assign sel = encode(mch);

endmodule

`default_nettype wire

// ==== hw/tcb_lite_lib_demultiplexer.sv ====
/*
 * TCB-Lite demultiplexer, one manager to two subordinates.
 * Requests fan out combinationally to the subordinate picked by sel.
 * The select of each accepted transfer is delayed by the bus response
 * delay and then steers the matching response back to the manager.
 */

`default_nettype none

`include "tcb_lite_params.svh"

module tcb_lite_lib_demultiplexer (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // from the decoder
    input  wire tcb_lite_sys_pkg::tcb_sel_t sel,
    // manager side
    tcb_lite_if.sub                         man,
    // subordinate side
    tcb_lite_if.man                         sub0,
    tcb_lite_if.man                         sub1
);

    import tcb_lite_pkg::*;
    import tcb_lite_sys_pkg::*;

    localparam int unsigned DLY = `TCB_DLY;

    // subordinate returns gathered for indexing
    logic     sub_rdy     [`TCB_IFN];
    logic     sub_rsp_vld [`TCB_IFN];
    tcb_rsp_t sub_rsp     [`TCB_IFN];

    // handshake on the manager side
    logic     trn;

    // in-flight select indices
    tcb_sel_t sel_dly [DLY];
    tcb_sel_t sel_rsp;

    //////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////

    // payload goes everywhere, vld only to the chosen one
    assign sub0.req = man.req;
    assign sub1.req = man.req;
    assign sub0.vld = man.vld & (sel == tcb_sel_t'(0));
    assign sub1.vld = man.vld & (sel == tcb_sel_t'(1));

    assign sub_rdy[0] = sub0.rdy;
    assign sub_rdy[1] = sub1.rdy;

    // accept comes from the selected subordinate
    assign man.rdy = sub_rdy[sel];
    assign trn     = man.vld & man.rdy;

    //////////////////////////////////////////////////
    // select delay
    //////////////////////////////////////////////////

    // stage 0 loads on a transfer, later stages just shift
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DLY; i++) begin
                sel_dly[i] <= '0;
            end
        end else begin
            if (trn) begin
                sel_dly[0] <= sel;
            end
            for (int i = 1; i < DLY; i++) begin
                sel_dly[i] <= sel_dly[i-1];
            end
        end
    end

    // index of the transfer whose response is due now
    assign sel_rsp = sel_dly[DLY-1];

    //////////////////////////////////////////////////
    // response path
    //////////////////////////////////////////////////

    assign sub_rsp_vld[0] = sub0.rsp_vld;
    assign sub_rsp_vld[1] = sub1.rsp_vld;
    assign sub_rsp[0]     = sub0.rsp;
    assign sub_rsp[1]     = sub1.rsp;

    // no back-pressure, just steer
    assign man.rsp_vld = sub_rsp_vld[sel_rsp];
    assign man.rsp     = sub_rsp[sel_rsp];

endmodule

`default_nettype wire

// ==== hw/tcb_lite_mem.sv ====
/*
 * TCB-Lite word memory subordinate.
 * Answers one cycle after each transfer and stalls one cycle after a write.
 * WRO set gives a RAM cleared at reset; WRO clear gives a read-only
 * table filled with a fixed pattern, where writes answer with an error.
 */

`default_nettype none

`include "tcb_lite_params.svh"

module tcb_lite_mem #(
    parameter int unsigned SIZ = `TCB_MEM_SIZ,  // words
    parameter bit          WRO = 1'b1           // writes allowed
)(
    input  wire logic clk,
    input  wire logic rst_n,
    tcb_lite_if.sub   tcb
);

    import tcb_lite_pkg::*;
    import tcb_lite_sys_pkg::*;

    localparam int unsigned DAT = `TCB_DAT;
    // byte offset bits below the word address
    localparam int unsigned OFS = $clog2(DAT/8);
    localparam int unsigned IDX = (SIZ > 1) ? $clog2(SIZ) : 1;
    // read-only fill pattern base
    localparam logic [DAT-1:0] ROM_BASE = 'hC0DE_0000;

    logic [DAT-1:0] mem [SIZ];
    logic [IDX-1:0] idx;
    logic           trn;
    logic           wen;
    mem_state_t     state;
    mem_state_t     state_nxt;

    // word index wraps at SIZ
    assign idx = IDX'(tcb.req.adr[`TCB_ADR-1:OFS] % SIZ);
    assign trn = tcb.vld & tcb.rdy;
    assign wen = trn & (tcb.req.op == TCB_WR);

    //////////////////////////////////////////////////
    // write-commit FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            MEM_IDLE: begin
                // rejected writes stall too
                if (wen) begin
                    state_nxt = MEM_COMMIT;
                end
            end
            MEM_COMMIT: begin
                state_nxt = MEM_IDLE;
            end
            default: begin
                state_nxt = MEM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MEM_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign tcb.rdy = (state == MEM_IDLE);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    // ram clears, rom gets base plus word index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int unsigned i = 0; i < SIZ; i++) begin
                mem[i] <= WRO ? '0 : ROM_BASE + DAT'(i);
            end
        end else if (wen && WRO) begin
            mem[idx] <= tcb.req.wdt;
        end
    end

    //////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////

    // one pulse per transfer, one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tcb.rsp_vld <= 1'b0;
        end else begin
            tcb.rsp_vld <= trn;
        end
    end

    // write answers zero data, error when read-only
    always_ff @(posedge clk) begin
        if (trn) begin
            if (wen) begin
                tcb.rsp.rdt <= '0;
                tcb.rsp.err <= ~WRO;
            end else begin
                tcb.rsp.rdt <= mem[idx];
                tcb.rsp.err <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/tcb_lite_sys.sv ====
/*
 * TCB-Lite subsystem top level.
 * One manager on plain ports, a decoder and demultiplexer, and two memory
 * subordinates: a RAM at the bottom 1 KiB and a read-only table that
 * answers every other address. Responses come one cycle after acceptance.
 */

`default_nettype none

`include "tcb_lite_params.svh"

module tcb_lite_sys (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // request
    input  wire logic                  req_vld,
    input  wire tcb_lite_pkg::tcb_op_t req_op,
    input  wire logic [`TCB_ADR-1:0]   req_adr,
    input  wire logic [`TCB_DAT-1:0]   req_wdt,
    output logic                       req_rdy,
    // response
    output logic                       rsp_vld,
    output logic [`TCB_DAT-1:0]        rsp_rdt,
    output logic                       rsp_err
);

    import tcb_lite_sys_pkg::*;

    // decoded subordinate
    tcb_sel_t sel;

    //////////////////////////////////////////////////
    // bus instances
    //////////////////////////////////////////////////

    tcb_lite_if tcb_man ();
    tcb_lite_if tcb_ram ();
    tcb_lite_if tcb_rom ();

    // plain ports onto the manager bus
    assign tcb_man.vld     = req_vld;
    assign tcb_man.req.op  = req_op;
    assign tcb_man.req.adr = req_adr;
    assign tcb_man.req.wdt = req_wdt;
    assign req_rdy         = tcb_man.rdy;
    assign rsp_vld         = tcb_man.rsp_vld;
    assign rsp_rdt         = tcb_man.rsp.rdt;
    assign rsp_err         = tcb_man.rsp.err;

    //////////////////////////////////////////////////
    // interconnect
    //////////////////////////////////////////////////

    // entry 0 ram, entry 1 catch-all rom
    tcb_lite_lib_decoder #(
        .DAM ('{`TCB_MAP_ROM, `TCB_MAP_RAM})
    ) dec (
        .tcb (tcb_man),
        .sel (sel)
    );

    tcb_lite_lib_demultiplexer dmx (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (sel),
        .man   (tcb_man),
        .sub0  (tcb_ram),
        .sub1  (tcb_rom)
    );

    //////////////////////////////////////////////////
    // subordinates
    //////////////////////////////////////////////////

    tcb_lite_mem #(.SIZ(`TCB_MEM_SIZ), .WRO(1'b1)) ram (
        .clk   (clk),
        .rst_n (rst_n),
        .tcb   (tcb_ram)
    );

    // writes here are refused
    tcb_lite_mem #(.SIZ(`TCB_MEM_SIZ), .WRO(1'b0)) rom (
        .clk   (clk),
        .rst_n (rst_n),
        .tcb   (tcb_rom)
    );

endmodule

`default_nettype wire

// ==== test/tcb_lite_sys_tb.sv ====
/*
 * Testbench for the TCB-Lite subsystem.
 * Directed RAM and ROM traffic first, then LFSR-driven mixed traffic.
 * Every accepted request queues its expected response from a reference
 * model, and a compare process checks each response against the queue.
 */

`default_nettype none

`include "tcb_lite_params.svh"

module tcb_lite_sys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import tcb_lite_pkg::*;

    localparam time CLK_PER = 100ns;
    localparam time DRV_DLY = 10ns;
    localparam int  RST_CYC = 3;
    localparam int  N_DIR   = 32;   // bound on the directed transfers
    localparam int  N_RND   = 200;
    localparam int  N_TXN   = N_DIR + N_RND;

    logic                clk;
    logic                rst_n;
    logic                req_vld;
    tcb_op_t             req_op;
    logic [`TCB_ADR-1:0] req_adr;
    logic [`TCB_DAT-1:0] req_wdt;
    logic                req_rdy;
    logic                rsp_vld;
    logic [`TCB_DAT-1:0] rsp_rdt;
    logic                rsp_err;

    // reference RAM image
    logic [`TCB_DAT-1:0] ram_model [256];
    // expected {rdt, err} and the cycle it is due in
    logic [32:0] exp_q [$];
    int          due_q [$];
    int          cyc;
    int          val_errs;
    int          rdy_errs;
    int          orphan_errs;
    int          missing_errs;
    logic [31:0] lfsr;
    // last accepted transfer, predicts the commit stall
    logic        prv_wr;
    logic        prv_rom;
    int          prv_cyc;

    tcb_lite_sys i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req_op  (req_op),
        .req_adr (req_adr),
        .req_wdt (req_wdt),
        .req_rdy (req_rdy),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    always #(CLK_PER/2) clk = ~clk;

    // cycle count, read at falling edges only
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////
    // random numbers and reference model
    //////////////////////////////////////////////////

    // right-shift galois form, taps 32 30 26 25
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    // anything above the bottom 1 KiB belongs to the rom
    function automatic logic is_rom(input logic [31:0] adr);
        return adr[31:10] != '0;
    endfunction

    // expected {rdt, err}
    function automatic logic [32:0] ref_rsp(input tcb_op_t op, input logic [31:0] adr);
        logic [7:0] wrd;
        wrd = adr[9:2];
        if (op == TCB_WR) begin
            return {32'h0, is_rom(adr)};
        end else if (is_rom(adr)) begin
            return {32'hC0DE_0000 + 32'(wrd), 1'b0};
        end
        return {ram_model[wrd], 1'b0};
    endfunction

    //////////////////////////////////////////////////
    // driver
    //////////////////////////////////////////////////

    // starts DRV_DLY after a rising edge, returns at the same point
    task automatic transfer(input tcb_op_t op, input logic [31:0] adr, input logic [31:0] wdt);
        logic stall;
        req_vld = 1'b1;
        req_op  = op;
        req_adr = adr;
        req_wdt = wdt;
        @(negedge clk);
        // a write to the same memory last cycle holds rdy low once
        stall = prv_wr && (prv_rom == is_rom(adr)) && (cyc == prv_cyc + 1);
        assert (req_rdy == !stall) else begin
            rdy_errs++;
            $display("ERROR at %0t ns: req_rdy %b, expected %b", $time, req_rdy, !stall);
        end
        // commit stall is over after one cycle
        if (stall && !req_rdy) begin
            @(negedge clk);
            assert (req_rdy) else begin
                rdy_errs++;
                $display("ERROR at %0t ns: req_rdy still low after the commit cycle", $time);
            end
        end
        while (!req_rdy) begin
            @(negedge clk);
        end
        // accepted at the coming rising edge
        exp_q.push_back(ref_rsp(op, adr));
        due_q.push_back(cyc + 1);
        if (op == TCB_WR && !is_rom(adr)) begin
            ram_model[adr[9:2]] = wdt;
        end
        prv_wr  = (op == TCB_WR);
        prv_rom = is_rom(adr);
        prv_cyc = cyc;
        @(posedge clk);
        #DRV_DLY;
        req_vld = 1'b0;
    endtask

    task automatic idle();
        req_vld = 1'b0;
        @(posedge clk);
        #DRV_DLY;
    endtask

    //////////////////////////////////////////////////
    // compare
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && rsp_vld) begin
            if (exp_q.size() == 0) begin
                orphan_errs++;
                $display("a response arrived at %0t ns with no request outstanding", $time);
            end else begin
                assert ({rsp_rdt, rsp_err} == exp_q[0]) else begin
                    val_errs++;
                    $display("ERROR at %0t ns: rsp %h/%b, expected %h/%b", $time,
                             rsp_rdt, rsp_err, exp_q[0][32:1], exp_q[0][0]);
                end
                assert (cyc == due_q[0]) else begin
                    val_errs++;
                    $display("ERROR at %0t ns: response in cycle %0d, due in %0d", $time,
                             cyc, due_q[0]);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] op_b;
        logic [31:0] rom_b;
        logic [31:0] ofs;
        logic [31:0] wdt;
        logic [31:0] gap;
        logic [31:0] adr;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_vld      = 1'b0;
        req_op       = TCB_RD;
        req_adr      = '0;
        req_wdt      = '0;
        lfsr         = 32'hd2f46a2c;
        cyc          = 0;
        val_errs     = 0;
        rdy_errs     = 0;
        orphan_errs  = 0;
        missing_errs = 0;
        prv_wr       = 1'b0;
        prv_rom      = 1'b0;
        prv_cyc      = 0;
        for (int i = 0; i < 256; i++) begin
            ram_model[i] = '0;
        end
        repeat (RST_CYC) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!rsp_vld && req_rdy) else begin
            val_errs++;
            $display("ERROR at %0t ns: bus not idle after reset", $time);
        end
        @(posedge clk);
        #DRV_DLY;

        // cleared ram, then write and read back with the commit stall
        transfer(TCB_RD, 32'h0000_0000, '0);
        transfer(TCB_WR, 32'h0000_0010, 32'h1234_5678);
        transfer(TCB_RD, 32'h0000_0010, '0);
        transfer(TCB_WR, 32'h0000_03FC, 32'hA5A5_0FF0);
        transfer(TCB_RD, 32'h0000_03FC, '0);
        // rom pattern, far outside the ram range
        transfer(TCB_RD, 32'h0000_0400, '0);
        transfer(TCB_RD, 32'h8000_0024, '0);
        transfer(TCB_RD, 32'hFFFF_FFFC, '0);
        // refused write leaves the pattern alone
        transfer(TCB_WR, 32'h0001_0020, 32'hDEAD_BEEF);
        transfer(TCB_RD, 32'h0001_0020, '0);
        // back-to-back reads, ram and rom in turn
        for (int i = 0; i < 8; i++) begin
            transfer(TCB_RD, {22'h0, 8'(i * 4), 2'b00}, '0);
            transfer(TCB_RD, {16'h0002, 6'h0, 8'(i), 2'b00}, '0);
        end

        // mixed traffic
        for (int i = 0; i < N_RND; i++) begin
            draw(1, op_b);
            draw(1, rom_b);
            draw(8, ofs);
            draw(32, wdt);
            draw(1, gap);
            if (rom_b[0]) begin
                adr = {16'h0001, 6'h0, ofs[7:0], 2'b00};
            end else begin
                adr = {22'h0, ofs[7:0], 2'b00};
            end
            transfer(tcb_op_t'(op_b[0]), adr, wdt);
            if (gap[0]) begin
                idle();
            end
        end

        // let the last response drain
        idle();
        repeat (2) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            missing_errs += exp_q.size();
            $display("%0d expected responses never arrived", exp_q.size());
        end
        $display("errors: %0d value, %0d ready, %0d unexpected, %0d missing",
                 val_errs, rdy_errs, orphan_errs, missing_errs);
        if (val_errs + rdy_errs + orphan_errs + missing_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // four cycles per transfer covers a stall and a gap, plus reset and drain
    initial begin
        #((N_TXN * 4 + RST_CYC + 8) * CLK_PER);
        $display("timeout: the transfers did not finish in %0d cycles", N_TXN * 4 + RST_CYC + 8);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tcb_lite_sys.f ====
+incdir+hw
hw/tcb_lite_pkg.sv
hw/tcb_lite_sys_pkg.sv
hw/tcb_lite_if.sv
hw/tcb_lite_lib_decoder.sv
hw/tcb_lite_lib_demultiplexer.sv
hw/tcb_lite_mem.sv
hw/tcb_lite_sys.sv
test/tcb_lite_sys_tb.sv

// ==== Makefile ====
# Verilator build and run of the TCB-Lite subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcb_lite_sys_tb
FILELIST  ?= tcb_lite_sys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
